/* common/vfpu_pkg.sv */
// Shared definitions for the five-lane vector FPU
package vfpu_pkg;

  // Lane geometry
  localparam int LANES  = 5;                // Lanes per vector
  localparam int WORD_W = 32;               // Bits per lane slice
  localparam int VEC_W  = LANES * WORD_W;   // Full vector width

  // Per-lane flag set, ordered Z N C V from the top
  localparam int FLAG_W = 4;
  localparam int FLAG_Z = 3;                // Packed result is zero
  localparam int FLAG_N = 2;                // Result sign
  localparam int FLAG_C = 1;                // Tied low in every unit
  localparam int FLAG_V = 0;                // Exponent out of range

  // Single precision, IEEE 754 binary32 layout
  localparam int SP_EXP_W = 8;
  localparam int SP_MAN_W = 23;
  localparam int SP_BIAS  = 127;

  // Half precision, binary16 layout in bits 15:0 of a lane
  localparam int HP_EXP_W = 5;
  localparam int HP_MAN_W = 10;
  localparam int HP_BIAS  = 15;

  // One lane word
  typedef logic [WORD_W-1:0] word_t;

  // One lane's flags
  typedef logic [FLAG_W-1:0] flags_t;

  // Opcode
  // Bit 1 picks multiply over add
  // Bit 0 picks half over single precision
  typedef enum logic [1:0]
  {
    FP_ADD32 = 2'd0,   // Single-precision add
    FP_ADD16 = 2'd1,   // Half-precision add
    FP_MUL32 = 2'd2,   // Single-precision multiply
    FP_MUL16 = 2'd3    // Half-precision multiply
  } fp_op_e;

  // All operands are treated as normal numbers with a hidden one
  // No special encodings are recognized
  // Results are truncated toward zero magnitude

endpackage

/* fpu_lane/fp_add.sv */
`timescale 1ns/1ps

// Floating-point adder, built for any exponent and mantissa width
// Truncating, normals only, no special values
module fp_add
  import vfpu_pkg::*;
#(
  parameter int EXP_W = SP_EXP_W,   // Exponent field width
  parameter int MAN_W = SP_MAN_W    // Stored fraction width
)
(
  input  logic [EXP_W+MAN_W:0] a,
  input  logic [EXP_W+MAN_W:0] b,
  output logic [EXP_W+MAN_W:0] result,
  output flags_t               flags
);

  localparam int SIG_W = MAN_W + 1;             // Hidden one plus fraction
  localparam int LZC_W = $clog2(SIG_W + 1);     // Enough for a count of SIG_W
  localparam int XW    = EXP_W + 2;             // Room for carry and negative exponent

  // Operand fields
  logic             sa, sb;
  logic [EXP_W-1:0] ea, eb;
  logic [SIG_W-1:0] siga, sigb;

  // Ordered operands
  logic             a_big;
  logic             s_big;
  logic [EXP_W-1:0] e_big, e_small;
  logic [SIG_W-1:0] sig_big, sig_small;

  // Datapath
  logic [EXP_W-1:0] exp_diff;
  logic [SIG_W-1:0] sig_shift;
  logic [SIG_W:0]   sum;
  logic [SIG_W-1:0] dif;
  logic [LZC_W-1:0] lzc;
  logic [SIG_W-1:0] norm;

  // Packed result pieces
  logic             sign_r;
  logic [XW-1:0]    exp_x;
  logic [MAN_W-1:0] man_r;

  assign sa   = a[EXP_W+MAN_W];
  assign sb   = b[EXP_W+MAN_W];
  assign ea   = a[EXP_W+MAN_W-1:MAN_W];
  assign eb   = b[EXP_W+MAN_W-1:MAN_W];
  assign siga = {1'b1, a[MAN_W-1:0]};   // Implicit leading one
  assign sigb = {1'b1, b[MAN_W-1:0]};

  // Larger exponent wins, then larger significand, a on a full tie
  assign a_big = (ea > eb) || ((ea == eb) && (siga >= sigb));

  assign s_big     = a_big ? sa : sb;
  assign e_big     = a_big ? ea : eb;
  assign e_small   = a_big ? eb : ea;
  assign sig_big   = a_big ? siga : sigb;
  assign sig_small = a_big ? sigb : siga;

  // Alignment, bits shifted out are dropped
  assign exp_diff  = e_big - e_small;
  assign sig_shift = sig_small >> exp_diff;

  // Both magnitude paths run in parallel
  assign sum = {1'b0, sig_big} + {1'b0, sig_shift};
  assign dif = sig_big - sig_shift;   // Never negative after ordering

  // Leading-zero count of the difference
  // Scanning upward lets the highest set bit win
  always_comb
  begin
    lzc = '0;
    for (int i = 0; i < SIG_W; i++)
    begin
      if (dif[i])
        lzc = LZC_W'(SIG_W - 1 - i);
    end
  end

  assign norm = dif << lzc;   // Leading one back at the top

  // Select and normalize
  always_comb
  begin
    if (sa == sb)
    begin
      sign_r = s_big;
      if (sum[SIG_W])
      begin
        // Carry out of the significand
        man_r = sum[SIG_W-1:1];
        exp_x = {2'b00, e_big} + 1'b1;
      end
      else
      begin
        man_r = sum[MAN_W-1:0];
        exp_x = {2'b00, e_big};
      end
    end
    else if (dif == '0)
    begin
      // Exact cancellation gives +0
      sign_r = 1'b0;
      man_r  = '0;
      exp_x  = '0;
    end
    else
    begin
      sign_r = s_big;   // Larger magnitude sets the sign
      man_r  = norm[MAN_W-1:0];
      exp_x  = {2'b00, e_big} - XW'(lzc);   // May go negative
    end
  end

  // Exponent field wraps modulo its width
  assign result = {sign_r, exp_x[EXP_W-1:0], man_r};

  // Flags
  always_comb
  begin
    flags         = '0;
    flags[FLAG_Z] = (result == '0);
    flags[FLAG_N] = sign_r;
    flags[FLAG_C] = 1'b0;
    // Any bit above the field means above max or below zero
    flags[FLAG_V] = |exp_x[XW-1:EXP_W];
  end

endmodule

/* fpu_lane/fp_mul.sv */
`timescale 1ns/1ps

// Floating-point multiplier, any format width
// One-step normalization, truncated fraction
module fp_mul
  import vfpu_pkg::*;
#(
  parameter int EXP_W = SP_EXP_W,   // Exponent field width
  parameter int MAN_W = SP_MAN_W,   // Stored fraction width
  parameter int BIAS  = SP_BIAS     // Exponent bias of the format
)
(
  input  logic [EXP_W+MAN_W:0] a,
  input  logic [EXP_W+MAN_W:0] b,
  output logic [EXP_W+MAN_W:0] result,
  output flags_t               flags
);

  localparam int SIG_W  = MAN_W + 1;
  localparam int PROD_W = 2 * SIG_W;    // Full product width
  localparam int XW     = EXP_W + 2;    // Signed room for e_a + e_b - bias + 1

  logic              sign_r;
  logic [EXP_W-1:0]  ea, eb;
  logic [SIG_W-1:0]  siga, sigb;
  logic [PROD_W-1:0] prod;
  logic [XW-1:0]     exp_sum;
  logic [XW-1:0]     exp_x;
  logic [MAN_W-1:0]  man_r;

  // Sign
  assign sign_r = a[EXP_W+MAN_W] ^ b[EXP_W+MAN_W];

  assign ea   = a[EXP_W+MAN_W-1:MAN_W];
  assign eb   = b[EXP_W+MAN_W-1:MAN_W];
  assign siga = {1'b1, a[MAN_W-1:0]};
  assign sigb = {1'b1, b[MAN_W-1:0]};

  // Biased exponent sum, wide so it can't wrap
  assign exp_sum = {2'b00, ea} + {2'b00, eb} - XW'(BIAS);

  // Significand product, lies in [1, 4)
  assign prod = siga * sigb;

  // Normalize by at most one position
  always_comb
  begin
    if (prod[PROD_W-1])
    begin
      man_r = prod[PROD_W-2 -: MAN_W];   // Just below the top bit
      exp_x = exp_sum + 1'b1;
    end
    else
    begin
      man_r = prod[PROD_W-3 -: MAN_W];
      exp_x = exp_sum;
    end
  end

  // Low bits of the exponent go in the field
  assign result = {sign_r, exp_x[EXP_W-1:0], man_r};

  always_comb
  begin
    flags         = '0;
    flags[FLAG_Z] = (result == '0);
    flags[FLAG_N] = sign_r;
    flags[FLAG_C] = 1'b0;
    flags[FLAG_V] = |exp_x[XW-1:EXP_W];   // Negative or past the field
  end

endmodule

/* fpu_lane/fpu_lane.sv */
`timescale 1ns/1ps

// One vector lane
// All four units run side by side, the opcode picks one
module fpu_lane
  import vfpu_pkg::*;
(
  input  fp_op_e op,
  input  word_t  a,
  input  word_t  b,
  output word_t  result,
  output flags_t flags
);

  localparam int HP_W = 1 + HP_EXP_W + HP_MAN_W;   // Half-precision word

  // Unit outputs
  word_t           add32_res, mul32_res;
  logic [HP_W-1:0] add16_res, mul16_res;
  flags_t          add32_flags, add16_flags;
  flags_t          mul32_flags, mul16_flags;

  fp_add #(.EXP_W(SP_EXP_W), .MAN_W(SP_MAN_W)) u_add32
  (
    .a      (a),
    .b      (b),
    .result (add32_res),
    .flags  (add32_flags)
  );

  // Half-precision units see only the low half of the lane
  fp_add #(.EXP_W(HP_EXP_W), .MAN_W(HP_MAN_W)) u_add16
  (
    .a      (a[HP_W-1:0]),
    .b      (b[HP_W-1:0]),
    .result (add16_res),
    .flags  (add16_flags)
  );

  fp_mul #(.EXP_W(SP_EXP_W), .MAN_W(SP_MAN_W), .BIAS(SP_BIAS)) u_mul32
  (
    .a      (a),
    .b      (b),
    .result (mul32_res),
    .flags  (mul32_flags)
  );

  fp_mul #(.EXP_W(HP_EXP_W), .MAN_W(HP_MAN_W), .BIAS(HP_BIAS)) u_mul16
  (
    .a      (a[HP_W-1:0]),
    .b      (b[HP_W-1:0]),
    .result (mul16_res),
    .flags  (mul16_flags)
  );

  // Opcode select, half results zero-extended
  always_comb
  begin
    case (op)
      FP_ADD16:
      begin
        result = {{(WORD_W-HP_W){1'b0}}, add16_res};
        flags  = add16_flags;
      end
      FP_MUL32:
      begin
        result = mul32_res;
        flags  = mul32_flags;
      end
      FP_MUL16:
      begin
        result = {{(WORD_W-HP_W){1'b0}}, mul16_res};
        flags  = mul16_flags;
      end
      default:   // FP_ADD32
      begin
        result = add32_res;
        flags  = add32_flags;
      end
    endcase
  end

endmodule

/* rtl/vfpu.sv */
`timescale 1ns/1ps

// Five-lane vector FPU
// Combinational lanes, one output register stage
module vfpu
  import vfpu_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst_n,
  input  fp_op_e                  op,       // Shared by all lanes
  input  logic [VEC_W-1:0]        va,
  input  logic [VEC_W-1:0]        vb,
  output logic [VEC_W-1:0]        vresult,
  output logic [LANES*FLAG_W-1:0] vflags
);

  // Lane outputs ahead of the register
  logic [VEC_W-1:0]        lane_res;
  logic [LANES*FLAG_W-1:0] lane_flags;

  // Lane k owns data bits k*32 up and flag bits k*4 up
  for (genvar k = 0; k < LANES; k++)
  begin : g_lane
    word_t  a_k, b_k;
    word_t  res_k;
    flags_t flags_k;

    assign a_k = va[k*WORD_W +: WORD_W];   // Slice operands
    assign b_k = vb[k*WORD_W +: WORD_W];

    fpu_lane u_lane
    (
      .op     (op),
      .a      (a_k),
      .b      (b_k),
      .result (res_k),
      .flags  (flags_k)
    );

    // Lane 0 lands in the low bits
    assign lane_res[k*WORD_W +: WORD_W]   = res_k;
    assign lane_flags[k*FLAG_W +: FLAG_W] = flags_k;
  end

  // Output stage
  // One-cycle latency, a new op every cycle
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      vresult <= '0;   // Cleared while in reset
      vflags  <= '0;
    end
    else
    begin
      vresult <= lane_res;
      vflags  <= lane_flags;
    end
  end

endmodule

/* test/vfpu_model.svh */
`ifndef VFPU_MODEL_SVH
`define VFPU_MODEL_SVH

// Lane reference model, integer arithmetic in longint
// Fields are masked out, so bits above the format never reach the math

// Packs sign, true exponent and fraction, then derives the flags
function automatic void pack_result(input longint sgn, input longint ex, input longint man,
                                    input int exp_w, input int man_w,
                                    output word_t res, output flags_t flg);
  longint emax;
  emax = (longint'(1) << exp_w) - 1;
  res  = word_t'((sgn << (exp_w + man_w)) | ((ex & emax) << man_w) | man);   // Field wraps
  flg  = '0;
  flg[FLAG_Z] = (res == '0);
  flg[FLAG_N] = sgn[0];
  flg[FLAG_V] = (ex < 0) || (ex > emax);   // True exponent out of the field
endfunction

// Truncating add of two normals
function automatic void model_add(input word_t a, input word_t b, input int exp_w,
                                  input int man_w, output word_t res, output flags_t flg);
  longint mmask, emask;
  longint sa, sb, ea, eb, siga, sigb;
  longint s_big, e_big, e_small, sig_big, sig_small, mag, ex;
  bit     a_big;
  mmask = (longint'(1) << man_w) - 1;
  emask = (longint'(1) << exp_w) - 1;
  sa    = (a >> (exp_w + man_w)) & 1;
  sb    = (b >> (exp_w + man_w)) & 1;
  ea    = (a >> man_w) & emask;
  eb    = (b >> man_w) & emask;
  siga  = (longint'(1) << man_w) | (a & mmask);   // Hidden one
  sigb  = (longint'(1) << man_w) | (b & mmask);
  a_big = (ea > eb) || ((ea == eb) && (siga >= sigb));
  s_big     = a_big ? sa : sb;
  e_big     = a_big ? ea : eb;
  e_small   = a_big ? eb : ea;
  sig_big   = a_big ? siga : sigb;
  sig_small = (a_big ? sigb : siga) >> (e_big - e_small);   // Align, lost bits dropped
  ex        = e_big;
  if (sa == sb)
  begin
    mag = sig_big + sig_small;
    if ((mag >> (man_w + 1)) != 0)
    begin
      mag = mag >> 1;   // Carry out
      ex  = ex + 1;
    end
    pack_result(s_big, ex, mag & mmask, exp_w, man_w, res, flg);
  end
  else
  begin
    mag = sig_big - sig_small;
    if (mag == 0)
      pack_result(0, 0, 0, exp_w, man_w, res, flg);   // Exact cancel
    else
    begin
      // Bring the leading one back to the hidden position
      while (((mag >> man_w) & 1) == 0)
      begin
        mag = mag << 1;
        ex  = ex - 1;
      end
      pack_result(s_big, ex, mag & mmask, exp_w, man_w, res, flg);
    end
  end
endfunction

// Truncating multiply with one-step normalize
function automatic void model_mul(input word_t a, input word_t b, input int exp_w,
                                  input int man_w, input int bias,
                                  output word_t res, output flags_t flg);
  longint mmask, emask, sgn, ex, prod, man;
  mmask = (longint'(1) << man_w) - 1;
  emask = (longint'(1) << exp_w) - 1;
  sgn   = ((a ^ b) >> (exp_w + man_w)) & 1;
  ex    = ((a >> man_w) & emask) + ((b >> man_w) & emask) - bias;
  prod  = ((longint'(1) << man_w) | (a & mmask)) * ((longint'(1) << man_w) | (b & mmask));
  if (((prod >> (2 * man_w + 1)) & 1) != 0)
  begin
    man = (prod >> (man_w + 1)) & mmask;   // Product in [2, 4)
    ex  = ex + 1;
  end
  else
    man = (prod >> man_w) & mmask;
  pack_result(sgn, ex, man, exp_w, man_w, res, flg);
endfunction

// One lane, any opcode
function automatic void model_op(input fp_op_e o, input word_t a, input word_t b,
                                 output word_t res, output flags_t flg);
  case (o)
    FP_ADD32: model_add(a, b, SP_EXP_W, SP_MAN_W, res, flg);
    FP_ADD16: model_add(a, b, HP_EXP_W, HP_MAN_W, res, flg);
    FP_MUL32: model_mul(a, b, SP_EXP_W, SP_MAN_W, SP_BIAS, res, flg);
    default:  model_mul(a, b, HP_EXP_W, HP_MAN_W, HP_BIAS, res, flg);
  endcase
endfunction

`endif

/* test/vfpu_tb.sv */
`timescale 1ns/1ps

// Vector FPU testbench, random vectors checked against the lane model
module vfpu_tb
  import vfpu_pkg::*;
();

  localparam int RST_CYCLES = 16;
  localparam int N_RAND     = 400;    // Vectors per opcode
  localparam int N_MIX      = 50;     // Mixed ops on each side of the mid reset
  // Roughly 1,750 cycles of tests, the rest is margin
  localparam int MAX_CYCLES = 2000;

  logic                    clk;
  logic                    rst_n;
  fp_op_e                  op;
  logic [VEC_W-1:0]        va, vb;
  logic [VEC_W-1:0]        vresult;
  logic [LANES*FLAG_W-1:0] vflags;

  integer seed      = 32'hfa15;
  int     cycles    = 0;
  int     n_checks  = 0;
  int     err_data  = 0;
  int     err_flags = 0;

  // Expected outputs, one entry per op in flight
  logic [VEC_W-1:0]        q_res[$];
  logic [LANES*FLAG_W-1:0] q_flg[$];
  string                   q_name[$];

  vfpu uut
  (
    .clk     (clk),
    .rst_n   (rst_n),
    .op      (op),
    .va      (va),
    .vb      (vb),
    .vresult (vresult),
    .vflags  (vflags)
  );

  `include "vfpu_model.svh"

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;   // 8 ns period
  end

  // Run limit
  always @(posedge clk)
  begin
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES)
    begin
      $display("Timed out after %0d cycles, the test sequence never finished", cycles);
      $display("Test failed");
      $finish;
    end
  end

  task automatic check_word(input string name, input word_t expv, input word_t act);
    n_checks++;
    if (act !== expv)
    begin
      err_data++;
      $display("ERR %s expected %h actual %h", name, expv, act);
    end
  endtask

  task automatic check_flags(input string name, input flags_t expv, input flags_t act);
    n_checks++;
    if (act !== expv)
    begin
      err_flags++;
      $display("ERR %s flags expected %b actual %b", name, expv, act);
    end
  endtask

  // Compares every lane of the registered outputs
  task automatic check_outputs(input string name, input logic [VEC_W-1:0] er,
                               input logic [LANES*FLAG_W-1:0] ef);
    for (int k = 0; k < LANES; k++)
    begin
      check_word($sformatf("%s lane %0d", name, k), er[k*WORD_W +: WORD_W],
                 vresult[k*WORD_W +: WORD_W]);
      check_flags($sformatf("%s lane %0d", name, k), ef[k*FLAG_W +: FLAG_W],
                  vflags[k*FLAG_W +: FLAG_W]);
    end
  endtask

  task automatic check_pending();
    if (q_res.size() > 0)
      check_outputs(q_name.pop_front(), q_res.pop_front(), q_flg.pop_front());
  endtask

  // Drives one op, then checks the op from the cycle before
  task automatic run_op(input fp_op_e o, input logic [VEC_W-1:0] a,
                        input logic [VEC_W-1:0] b, input string name);
    logic [VEC_W-1:0]        er;
    logic [LANES*FLAG_W-1:0] ef;
    word_t                   r;
    flags_t                  f;
    for (int k = 0; k < LANES; k++)
    begin
      model_op(o, a[k*WORD_W +: WORD_W], b[k*WORD_W +: WORD_W], r, f);
      er[k*WORD_W +: WORD_W] = r;
      ef[k*FLAG_W +: FLAG_W] = f;
    end
    @(posedge clk);
    op <= o;
    va <= a;
    vb <= b;
    q_res.push_back(er);
    q_flg.push_back(ef);
    q_name.push_back(name);
    @(negedge clk);   // Outputs settled
    if (q_res.size() > 1)
      check_pending();
  endtask

  task automatic flush_pipe();
    @(posedge clk);
    @(negedge clk);
    check_pending();
  endtask

  // Random lane word, narrow mode keeps exponents close
  function automatic word_t rand_word(input fp_op_e o, input int mode);
    word_t w;
    w = $random(seed);   // Sign, fraction and upper junk for half ops
    if (mode != 0 && (o == FP_ADD32 || o == FP_MUL32))
      w[30:23] = 8'd124 + 8'($random(seed) & 7);
    else if (mode != 0)
      w[14:10] = 5'd13 + 5'($random(seed) & 3);
    return w;
  endfunction

  task automatic rand_vectors(input fp_op_e o, output logic [VEC_W-1:0] a,
                              output logic [VEC_W-1:0] b);
    int    mode;
    word_t wa;
    for (int k = 0; k < LANES; k++)
    begin
      mode = $random(seed) & 3;
      wa   = rand_word(o, mode);
      a[k*WORD_W +: WORD_W] = wa;
      if (mode == 3)   // Negated copy, cancels to zero on add
        b[k*WORD_W +: WORD_W] = (o == FP_ADD32 || o == FP_MUL32) ? wa ^ 32'h8000_0000
                                                                 : wa ^ 32'h0000_8000;
      else
        b[k*WORD_W +: WORD_W] = rand_word(o, mode);
    end
  endtask

  task automatic run_random(input fp_op_e o, input int n, input string name);
    logic [VEC_W-1:0] a, b;
    repeat (n)
    begin
      rand_vectors(o, a, b);
      run_op(o, a, b, name);
    end
  endtask

  // New opcode every cycle
  task automatic run_mixed(input int n);
    fp_op_e           o;
    logic [VEC_W-1:0] a, b;
    repeat (n)
    begin
      o = fp_op_e'($random(seed) & 3);
      rand_vectors(o, a, b);
      run_op(o, a, b, $sformatf("mixed_%s", o.name()));
    end
  endtask

  task automatic reset_mid();
    @(posedge clk);
    rst_n <= 1'b0;
    @(negedge clk);
    check_pending();   // Last op got in before reset
    @(posedge clk);
    @(negedge clk);
    check_outputs("mid_reset", '0, '0);
    @(posedge clk);
    rst_n <= 1'b1;
  endtask

  initial
  begin
    rst_n = 1'b0;
    op    = FP_ADD32;
    va    = '0;
    vb    = '0;
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    check_outputs("reset_hold", '0, '0);
    @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_outputs("after_reset", '0, '0);   // Nothing issued yet

    run_random(FP_ADD32, N_RAND, "add32");
    flush_pipe();
    run_random(FP_ADD16, N_RAND, "add16");
    flush_pipe();
    run_random(FP_MUL32, N_RAND, "mul32");
    flush_pipe();
    run_random(FP_MUL16, N_RAND, "mul16");
    flush_pipe();

    // Exponent extremes and exact cancellation
    run_op(FP_MUL32, {LANES{32'h7f80_0000}}, {LANES{32'h7f80_0000}}, "mul32_ovf");
    run_op(FP_MUL32, {LANES{32'h8000_0000}}, {LANES{32'h0000_0000}}, "mul32_unf");
    run_op(FP_MUL16, {LANES{32'h0000_7c00}}, {LANES{32'h0000_7c00}}, "mul16_ovf");
    run_op(FP_MUL16, {LANES{32'h0000_0000}}, {LANES{32'h0000_8000}}, "mul16_unf");
    run_op(FP_ADD32, {LANES{32'h7f80_0000}}, {LANES{32'h7f80_0000}}, "add32_ovf");
    run_op(FP_ADD32, {LANES{32'h0000_0001}}, {LANES{32'h8000_0000}}, "add32_unf");
    run_op(FP_ADD32, {LANES{32'h3f80_0000}}, {LANES{32'hbf80_0000}}, "add32_zero");
    run_op(FP_ADD16, {LANES{32'h0000_3c00}}, {LANES{32'h0000_bc00}}, "add16_zero");
    flush_pipe();

    run_mixed(N_MIX);
    reset_mid();
    run_mixed(N_MIX);
    flush_pipe();

    $display("Checks %0d, data errors %0d, flag errors %0d", n_checks, err_data, err_flags);
    if (err_data + err_flags == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule

/* vlog.f */
+incdir+test
common/vfpu_pkg.sv
fpu_lane/fp_add.sv
fpu_lane/fp_mul.sv
fpu_lane/fpu_lane.sv
rtl/vfpu.sv
test/vfpu_tb.sv
